// File: files.f
+incdir+rtl
rtl/stoplightPkg.sv
rtl/gameControl.sv
rtl/phaseTimer.sv
rtl/ledChaser.sv
rtl/segmentDisplay.sv
rtl/stoplightGame.sv
tests/stoplightGameTb.sv

// File: rtl/gameControl.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module gameControl (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   btnC,        // Start
    input  logic                   btnR,        // Stop
    input  logic                   btnL,        // Return
    input  logic                   onTarget,
    input  logic                   periodEnd,
    input  logic [2:0]             periodCount,
    output stoplightPkg::gameState state,
    output logic                   restart,
    output stoplightPkg::gameLevel level
);
    import stoplightPkg::*;

    localparam logic [2:0] lastFlash = 3'(`VICTORY_FLASHES - 1);
    localparam logic [2:0] lastBlink = 3'(`DEFEAT_BLINKS - 1);

    gameState nextState;
    gameState resumeState;  // Where a victory leads
    logic     inLevel;

    assign inLevel = (state == stLevel1) || (state == stLevel2) || (state == stLevel3);

    //////////////////////////////
    // Next state
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (btnC) nextState = stLevel1;
            end
            stLevel1, stLevel2, stLevel3: begin
                if (btnR) nextState = onTarget ? stVictory : stDefeat;
            end
            stVictory: begin
                if (periodEnd && (periodCount == lastFlash)) nextState = resumeState;
            end
            stDefeat: begin
                if (periodEnd && (periodCount == lastBlink)) nextState = stIdle;
            end
            stFinish: begin
                if (btnL) nextState = stIdle;
            end
            default: nextState = stIdle;
        endcase
    end

    // High on the edge that enters a new state
    assign restart = (nextState != state);

    //////////////////////////////
    // Registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resumeState <= stLevel2;
        end else if (inLevel && btnR) begin
            // Level 3 win ends the game
            resumeState <= (state == stLevel3) ? stFinish : gameState'(state + 3'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            level <= 3'd0;
        end else if (restart) begin
            case (nextState)
                stIdle:   level <= 3'd0;
                stLevel1: level <= 3'd1;
                stLevel2: level <= 3'd2;
                stLevel3: level <= 3'd3;
                stFinish: level <= 3'd4;
                default:  level <= level; // Victory and defeat keep the digit
            endcase
        end
    end

    //////////////////////////////
    // Checks
    stateDefined: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(state) && (state <= stFinish))
        else $error("gameControl state out of range");

endmodule

// File: rtl/ledChaser.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module ledChaser (
    input  logic                   clk,
    input  logic                   rstN,
    input  stoplightPkg::gameState state,
    input  logic                   restart,
    input  logic                   onPhase,
    input  logic                   periodEnd,
    output logic [`LED_COUNT-1:0]  led,
    output logic                   onTarget
);
    import stoplightPkg::*;

    localparam int ledCount = `LED_COUNT;
    localparam int posW     = $clog2(ledCount);
    localparam logic [ledCount-1:0] evenMask = {(ledCount/2){2'b01}};

    logic [posW-1:0]     pos;
    logic [ledCount-1:0] posOneHot;
    logic                inLevel;

    assign inLevel   = (state == stLevel1) || (state == stLevel2) || (state == stLevel3);
    assign posOneHot = {{(ledCount-1){1'b0}}, 1'b1} << pos;
    assign onTarget  = (pos == posW'(`TARGET_POS));

    //////////////////////////////
    // Chase position
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pos <= '0;
        end else if (restart) begin
            if (!inLevel) pos <= '0; // Leaving a level keeps the stopped spot
        end else if (inLevel && periodEnd) begin
            pos <= (pos == posW'(ledCount - 1)) ? '0 : pos + 1'b1;
        end
    end

    //////////////////////////////
    // Bar pattern
    always_comb begin
        case (state)
            stIdle:                       led = onPhase ? evenMask : ~evenMask;
            stLevel1, stLevel2, stLevel3: led = posOneHot;
            stDefeat:                     led = onPhase ? posOneHot : '0;
            stVictory, stFinish:          led = onPhase ? '1 : '0;
            default:                      led = '0;
        endcase
    end

    // Exactly one LED while chasing
    chaseOneHot: assert property (@(posedge clk) disable iff (!rstN)
        (state inside {stLevel1, stLevel2, stLevel3}) |-> $onehot(led))
        else $error("led not one-hot during chase");

endmodule

// File: rtl/phaseTimer.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module phaseTimer #(
    parameter int secondTicks = `SECOND_TICKS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  stoplightPkg::gameState state,
    input  logic                   restart,
    output logic                   onPhase,
    output logic                   periodEnd,
    output logic [2:0]             periodCount
);
    import stoplightPkg::*;

    localparam int cntW = $clog2(secondTicks + 1);

    logic [cntW-1:0] cycleCount;
    logic [cntW-1:0] periodLen;
    logic [cntW-1:0] onLen;     // Lit part of the period

    // Period and duty per state
    always_comb begin
        case (state)
            stLevel1: begin
                periodLen = cntW'(secondTicks / 8);
                onLen     = cntW'(secondTicks / 8);
            end
            stLevel2: begin
                periodLen = cntW'(secondTicks / 16);
                onLen     = cntW'(secondTicks / 16);
            end
            stLevel3: begin
                periodLen = cntW'(secondTicks / 24);
                onLen     = cntW'(secondTicks / 24);
            end
            stDefeat, stFinish: begin
                periodLen = cntW'(secondTicks / 2);
                onLen     = cntW'(secondTicks / 4);
            end
            default: begin  // Idle and victory
                periodLen = cntW'(secondTicks);
                onLen     = cntW'(secondTicks / 2);
            end
        endcase
    end

    assign periodEnd = (cycleCount == periodLen - 1'b1);
    assign onPhase   = (cycleCount < onLen);

    always_ff @(posedge clk) begin
        if (!rstN || restart) begin
            cycleCount  <= '0;
            periodCount <= 3'd0;
        end else if (periodEnd) begin
            cycleCount  <= '0;
            periodCount <= periodCount + 3'd1;
        end else begin
            cycleCount <= cycleCount + 1'b1;
        end
    end

    noBackToBackEnd: assert property (@(posedge clk) disable iff (!rstN)
        periodEnd |=> !periodEnd)
        else $error("periodEnd on consecutive cycles");

endmodule

// File: rtl/segmentDisplay.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module segmentDisplay (
    input  logic                   clk,
    input  logic                   rstN,
    input  stoplightPkg::gameLevel level,
    output logic [6:0]             seg,
    output logic [3:0]             an
);
    localparam int muxW = $clog2(`MUX_TICKS + 1);

    logic [muxW-1:0] muxCount;
    logic            digitSel;   // 0 right, 1 left
    logic [3:0]      leftDigit;
    logic [3:0]      rightDigit;
    logic [3:0]      digit;
    logic [6:0]      segNext;

    // Digit select toggles every MUX_TICKS
    always_ff @(posedge clk) begin
        if (!rstN) begin
            muxCount <= '0;
            digitSel <= 1'b0;
        end else if (muxCount == muxW'(`MUX_TICKS - 1)) begin
            muxCount <= '0;
            digitSel <= ~digitSel;
        end else begin
            muxCount <= muxCount + 1'b1;
        end
    end

    assign leftDigit  = (level != 3'd0) ? 4'd8 : 4'd0; // Target shown once playing
    assign rightDigit = {1'b0, level};
    assign digit      = digitSel ? leftDigit : rightDigit;

    always_comb begin
        case (digit)
            4'd0:    segNext = `SEG_0;
            4'd1:    segNext = `SEG_1;
            4'd2:    segNext = `SEG_2;
            4'd3:    segNext = `SEG_3;
            4'd4:    segNext = `SEG_4;
            4'd5:    segNext = `SEG_5;
            4'd6:    segNext = `SEG_6;
            4'd7:    segNext = `SEG_7;
            4'd8:    segNext = `SEG_8;
            4'd9:    segNext = `SEG_9;
            default: segNext = `SEG_BLANK;
        endcase
    end

    // Pattern and anode leave together
    always_ff @(posedge clk) begin
        if (!rstN) begin
            seg <= `SEG_BLANK;
            an  <= `AN_RIGHT;
        end else begin
            seg <= segNext;
            an  <= digitSel ? `AN_LEFT : `AN_RIGHT;
        end
    end

    anodeValid: assert property (@(posedge clk) disable iff (!rstN)
        (an == `AN_RIGHT) || (an == `AN_LEFT))
        else $error("an holds an unused anode code");

endmodule

// File: rtl/stoplightGame.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module stoplightGame #(
    parameter int secondTicks = `SECOND_TICKS_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  btnC,
    input  logic                  btnR,
    input  logic                  btnL,
    output logic [`LED_COUNT-1:0] led,
    output logic [6:0]            seg,
    output logic [3:0]            an
);
    import stoplightPkg::*;

    gameState   state;
    gameLevel   level;
    logic       restart;
    logic       onPhase;
    logic       periodEnd;
    logic [2:0] periodCount;
    logic       onTarget;

    //////////////////////////////
    // Control and timing
    gameControl control (
        .clk(clk), .rstN(rstN),
        .btnC(btnC), .btnR(btnR), .btnL(btnL),
        .onTarget(onTarget), .periodEnd(periodEnd), .periodCount(periodCount),
        .state(state), .restart(restart), .level(level)
    );

    phaseTimer #(.secondTicks(secondTicks)) timer (
        .clk(clk), .rstN(rstN), .state(state), .restart(restart),
        .onPhase(onPhase), .periodEnd(periodEnd), .periodCount(periodCount)
    );

    //////////////////////////////
    // Outputs
    ledChaser chaser (
        .clk(clk), .rstN(rstN), .state(state), .restart(restart),
        .onPhase(onPhase), .periodEnd(periodEnd),
        .led(led), .onTarget(onTarget)
    );

    segmentDisplay display (
        .clk(clk), .rstN(rstN), .level(level), .seg(seg), .an(an)
    );

endmodule

// File: rtl/stoplightPkg.sv
package stoplightPkg;

    // Game FSM states
    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stLevel1  = 3'd1,
        stLevel2  = 3'd2,
        stLevel3  = 3'd3,
        stVictory = 3'd4,
        stDefeat  = 3'd5,
        stFinish  = 3'd6
    } gameState;

    // Level digit on the display
    // 0 in idle, 1 to 3 while playing, 4 at finish
    typedef logic [2:0] gameLevel;

endpackage

// File: rtl/stoplight_params.svh
`ifndef STOPLIGHT_PARAMS_SVH
`define STOPLIGHT_PARAMS_SVH

// LED bar and target
`define LED_COUNT            16
`define TARGET_POS           8

`define SECOND_TICKS_DEFAULT 96_000_000 // Multiple of 48
`define MUX_TICKS            16         // Cycles per display digit
`define VICTORY_FLASHES      3
`define DEFEAT_BLINKS        4

// Active-low segments, gfedcba
`define SEG_0     7'b1000000
`define SEG_1     7'b1111001
`define SEG_2     7'b0100100
`define SEG_3     7'b0110000
`define SEG_4     7'b0011001
`define SEG_5     7'b0010010
`define SEG_6     7'b0000010
`define SEG_7     7'b1111000
`define SEG_8     7'b0000000
`define SEG_9     7'b0011000
`define SEG_BLANK 7'b1111111

`define AN_RIGHT  4'b1110
`define AN_LEFT   4'b0111

`endif

// File: tests/stoplightGameTb.sv
`timescale 1ns/1ps
`include "stoplight_params.svh"

module stoplightGameTb;
    import stoplightPkg::*;

    localparam int secondTicks    = 480;
    localparam int games          = 30;
    localparam int settleTicks    = 2 * `MUX_TICKS + 2;  // Display latency after a level change
    localparam int watchdogCycles = games * (9 * secondTicks + 200);

    logic                  clk, rstN, btnC, btnR, btnL;
    logic [`LED_COUNT-1:0] led;
    logic [6:0]            seg;
    logic [3:0]            an;
    gameState mState, mResume;     // Model state and where a win leads
    gameLevel mLevel;
    int       mAge, mLevelAge, mPos;  // Cycles in state, cycles since level change, chase spot
    integer   seed;

    stoplightGame #(.secondTicks(secondTicks)) UUT (
        .clk(clk), .rstN(rstN), .btnC(btnC), .btnR(btnR), .btnL(btnL),
        .led(led), .seg(seg), .an(an)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // Model helpers
    function automatic bit inLevel(input gameState st);
        return (st == stLevel1) || (st == stLevel2) || (st == stLevel3);
    endfunction

    function automatic int periodOf(input gameState st);
        case (st)
            stLevel1:           return secondTicks / 8;
            stLevel2:           return secondTicks / 16;
            stLevel3:           return secondTicks / 24;
            stDefeat, stFinish: return secondTicks / 2;
            default:            return secondTicks;
        endcase
    endfunction

    // Lit half of every blinking period
    function automatic logic [`LED_COUNT-1:0] expectedLed(input gameState st, input int age,
                                                        input int pos);
        logic [`LED_COUNT-1:0] evens;
        logic [`LED_COUNT-1:0] spot;
        bit                    lit;
        for (int i = 0; i < `LED_COUNT; i++) evens[i] = (i % 2 == 0);
        spot = '0;
        spot[pos] = 1'b1;
        lit = (age % periodOf(st)) < (periodOf(st) / 2);
        if (inLevel(st)) return spot;
        case (st)
            stIdle:   return lit ? evens : ~evens;
            stDefeat: return lit ? spot : '0;
            default:  return lit ? '1 : '0;   // Victory and finish
        endcase
    endfunction

    function automatic logic [6:0] segPattern(input int digit);
        case (digit)
            0:       return `SEG_0;
            1:       return `SEG_1;
            2:       return `SEG_2;
            3:       return `SEG_3;
            4:       return `SEG_4;
            8:       return `SEG_8;
            default: return `SEG_BLANK;
        endcase
    endfunction

    //////////////////////////////
    // Compare tasks
    task automatic abortRun;
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkLed(input logic [`LED_COUNT-1:0] expected);
        if (led !== expected) begin
            $display("** Error at %0t: led expected %h, got %h", $time, expected, led);
            abortRun();
        end
    endtask

    // State seen through the shape of the bar
    task automatic checkState(input gameState expected);
        logic [`LED_COUNT-1:0] evens;
        bit                    shapeOk;
        for (int i = 0; i < `LED_COUNT; i++) evens[i] = (i % 2 == 0);
        case (expected)
            stIdle:                       shapeOk = (led === evens) || (led === ~evens);
            stLevel1, stLevel2, stLevel3: shapeOk = $onehot(led);
            stDefeat:                     shapeOk = $onehot0(led);
            default:                      shapeOk = (led === '1) || (led === '0);
        endcase
        if (!shapeOk) begin
            $display("** Error at %0t: led %h does not fit state %0d", $time, led, expected);
            abortRun();
        end
    endtask

    task automatic checkDisplay(input gameLevel expected);
        logic [6:0] expSeg;
        if ((an !== `AN_RIGHT) && (an !== `AN_LEFT)) begin
            $display("** Error at %0t: an holds unused code %b", $time, an);
            abortRun();
        end else begin
            if (an === `AN_RIGHT) expSeg = segPattern(expected);
            else expSeg = segPattern((expected != 0) ? 8 : 0);  // Target digit once playing
            if (seg !== expSeg) begin
                $display("** Error at %0t: seg expected %b, got %b (an %b, level %0d)",
                         $time, expSeg, seg, an, expected);
                abortRun();
            end
        end
    endtask

    //////////////////////////////
    // Reference model, one step per clock
    always @(posedge clk) begin : referenceModel
        gameState next;
        gameLevel nextLevel;
        if (!rstN) begin
            mState = stIdle;
            mAge = 0;
            mPos = 0;
            mLevel = 0;
            mLevelAge = 0;
        end else begin
            next = mState;
            if (mState == stIdle && btnC) next = stLevel1;
            if (inLevel(mState) && btnR) begin
                next = (mPos == `TARGET_POS) ? stVictory : stDefeat;
                if (mState == stLevel1) mResume = stLevel2;
                else if (mState == stLevel2) mResume = stLevel3;
                else mResume = stFinish;
            end
            if (mState == stVictory && mAge == `VICTORY_FLASHES * secondTicks - 1) next = mResume;
            if (mState == stDefeat && mAge == `DEFEAT_BLINKS * (secondTicks / 2) - 1) next = stIdle;
            if (mState == stFinish && btnL) next = stIdle;
            mAge = (next != mState) ? 0 : mAge + 1;
            case (next)
                stIdle:   nextLevel = 0;
                stLevel1: nextLevel = 1;
                stLevel2: nextLevel = 2;
                stLevel3: nextLevel = 3;
                stFinish: nextLevel = 4;
                default:  nextLevel = mLevel;  // Digit held through victory and defeat
            endcase
            mLevelAge = (nextLevel != mLevel) ? 0 : mLevelAge + 1;
            mLevel = nextLevel;
            mState = next;
            if (inLevel(mState)) mPos = (mAge / periodOf(mState)) % `LED_COUNT;
        end
    end

    always @(negedge clk) begin
        if (rstN) begin
            checkState(mState);
            checkLed(expectedLed(mState, mAge, mPos));
            if (mLevelAge >= settleTicks) checkDisplay(mLevel);
        end
    end

    task automatic nextCycle;
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // Stimulus
    initial begin : stimulus
        bit playing;
        clk = 1'b0;
        rstN = 1'b0;
        btnC = 1'b0;
        btnR = 1'b0;
        btnL = 1'b0;
        seed = 15;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int game = 0; game < games; game++) begin
            repeat ($random(seed) & 15) nextCycle();
            btnC = 1'b1;
            nextCycle();
            btnC = 1'b0;
            playing = 1'b1;
            while (playing) begin
                if ($random(seed) & 1) begin
                    while (mPos != `TARGET_POS) nextCycle();  // Aim at the target
                end else begin
                    repeat ($random(seed) & 255) nextCycle();
                end
                btnR = 1'b1;
                nextCycle();
                btnR = 1'b0;
                while (mState == stVictory || mState == stDefeat) nextCycle();
                if (mState == stFinish) begin
                    repeat ($random(seed) & 255) nextCycle();
                    btnL = 1'b1;
                    nextCycle();
                    btnL = 1'b0;
                end
                playing = (mState != stIdle);
            end
        end
        repeat (settleTicks) nextCycle();
        $display("Simulation PASSED");
        $finish;
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired, the run timed out after %0d cycles", watchdogCycles);
        abortRun();
    end

endmodule
